//--- include/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// first fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// fetching from here ends execution
`define MIPS_HALT_ADDR 32'h00000000

// architectural register count
`define MIPS_REG_COUNT 32

// datapath word width
`define MIPS_WORD_BITS 32

`endif

//--- source/mips_isa_pkg.sv
`include "mips_config.svh"

package mips_isa_pkg;

    typedef logic [`MIPS_WORD_BITS-1:0] word_t;

    // raw instruction fields, R-type layout
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    typedef enum logic [5:0] {
        F_SLL   = 6'h00,
        F_SRL   = 6'h02,
        F_JR    = 6'h08,
        F_JALR  = 6'h09,
        F_MFHI  = 6'h10,
        F_MFLO  = 6'h12,
        F_MULT  = 6'h18,
        F_MULTU = 6'h19,
        F_ADDU  = 6'h21,
        F_SUBU  = 6'h23,
        F_AND   = 6'h24,
        F_OR    = 6'h25,
        F_XOR   = 6'h26,
        F_SLT   = 6'h2A,
        F_SLTU  = 6'h2B
    } funct_e;

    // rt field selects the branch under REGIMM
    typedef enum logic [4:0] {
        RT_BLTZAL = 5'b10000,
        RT_BGEZAL = 5'b10001
    } regimm_e;

    // I-type immediate spans rd, shamt and funct
    function automatic logic [15:0] imm16(instr_t instr);
        return {instr.rd, instr.shamt, instr.funct};
    endfunction

endpackage

//--- source/mips_ctrl_pkg.sv
package mips_ctrl_pkg;

    import mips_isa_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        WB_ALU,
        WB_MEM,
        WB_HI,
        WB_LO,
        WB_LINK
    } wb_sel_e;

    // destination register: rt, rd or r31 for links
    typedef enum logic [1:0] {
        DST_RT,
        DST_RD,
        DST_RA
    } dst_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     use_imm;
        logic     imm_zero_ext;
        logic     reg_write;
        wb_sel_e  wb_sel;
        dst_sel_e dst_sel;
        logic     mem_read;
        logic     mem_write;
        logic     branch_eq;
        logic     branch_ne;
        logic     branch_sign;
        logic     jump_imm;
        logic     jump_reg;
        logic     mul_start;
        logic     mul_signed;
    } ctrl_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } hilo_t;

endpackage

//--- source/mips_state_reg.sv
module mips_state_reg #(
    parameter type      payload_t   = logic,
    parameter payload_t RESET_VALUE = payload_t'(0)
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     enable,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk) begin
        if (reset) begin
            q <= RESET_VALUE;
        end else if (enable) begin
            q <= d;
        end
    end

endmodule

//--- source/mips_decoder.sv
module mips_decoder
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
    input  instr_t instr,
    output ctrl_t  ctrl
);

    // R-type ALU op from the function code
    task automatic set_rtype(input alu_op_e op);
        ctrl.alu_op    = op;
        ctrl.reg_write = 1'b1;
        ctrl.dst_sel   = DST_RD;
    endtask

    // immediate ALU op writing rt
    task automatic set_itype(input alu_op_e op, input logic zero_ext);
        ctrl.alu_op       = op;
        ctrl.use_imm      = 1'b1;
        ctrl.imm_zero_ext = zero_ext;
        ctrl.reg_write    = 1'b1;
    endtask

    always_comb begin
        // unknown encodings fall through as a nop
        ctrl         = '0;
        ctrl.alu_op  = ALU_ADD;
        ctrl.wb_sel  = WB_ALU;
        ctrl.dst_sel = DST_RT;

        case (instr.opcode)
            OP_SPECIAL: begin
                case (instr.funct)
                    F_ADDU: set_rtype(ALU_ADD);
                    F_SUBU: set_rtype(ALU_SUB);
                    F_AND:  set_rtype(ALU_AND);
                    F_OR:   set_rtype(ALU_OR);
                    F_XOR:  set_rtype(ALU_XOR);
                    F_SLT:  set_rtype(ALU_SLT);
                    F_SLTU: set_rtype(ALU_SLTU);
                    F_SLL:  set_rtype(ALU_SLL);
                    F_SRL:  set_rtype(ALU_SRL);
                    F_JR:   ctrl.jump_reg = 1'b1;
                    F_JALR: begin
                        ctrl.jump_reg  = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.wb_sel    = WB_LINK;
                        ctrl.dst_sel   = DST_RD;
                    end
                    F_MULT: begin
                        ctrl.mul_start  = 1'b1;
                        ctrl.mul_signed = 1'b1;
                    end
                    F_MULTU: ctrl.mul_start = 1'b1;
                    F_MFHI: begin
                        set_rtype(ALU_ADD);
                        ctrl.wb_sel = WB_HI;
                    end
                    F_MFLO: begin
                        set_rtype(ALU_ADD);
                        ctrl.wb_sel = WB_LO;
                    end
                    default: ;
                endcase
            end
            OP_REGIMM: begin
                // link is written whether or not the branch is taken
                if (instr.rt == RT_BLTZAL || instr.rt == RT_BGEZAL) begin
                    ctrl.branch_sign = 1'b1;
                    ctrl.reg_write   = 1'b1;
                    ctrl.wb_sel      = WB_LINK;
                    ctrl.dst_sel     = DST_RA;
                end
            end
            OP_J:   ctrl.jump_imm = 1'b1;
            OP_JAL: begin
                ctrl.jump_imm  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_LINK;
                ctrl.dst_sel   = DST_RA;
            end
            OP_BEQ:   ctrl.branch_eq = 1'b1;
            OP_BNE:   ctrl.branch_ne = 1'b1;
            OP_ADDIU: set_itype(ALU_ADD, 1'b0);
            OP_SLTI:  set_itype(ALU_SLT, 1'b0);
            OP_ANDI:  set_itype(ALU_AND, 1'b1);
            OP_ORI:   set_itype(ALU_OR, 1'b1);
            OP_XORI:  set_itype(ALU_XOR, 1'b1);
            OP_LUI:   set_itype(ALU_LUI, 1'b1);
            OP_LW: begin
                ctrl.mem_read  = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_MEM;
            end
            OP_SW:   ctrl.mem_write = 1'b1;
            default: ;
        endcase
    end

endmodule

//--- source/mips_regfile.sv
`include "mips_config.svh"

module mips_regfile
    import mips_isa_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       write_en,
    input  logic [4:0] read_a_index,
    input  logic [4:0] read_b_index,
    input  logic [4:0] write_index,
    input  word_t      write_data,
    output word_t      read_a_data,
    output word_t      read_b_data,
    output word_t      register_v0
);

    word_t regs [`MIPS_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_index != 5'd0) begin
            regs[write_index] <= write_data;
        end
    end

    // r0 is hardwired to zero
    assign read_a_data = (read_a_index == 5'd0) ? '0 : regs[read_a_index];
    assign read_b_data = (read_b_index == 5'd0) ? '0 : regs[read_b_index];

    // v0 is r2
    assign register_v0 = regs[2];

endmodule

//--- source/mips_alu.sv
module mips_alu
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
    input  word_t  op_a,
    input  word_t  op_b,
    input  instr_t instr,
    input  ctrl_t  ctrl,
    output word_t  result,
    output word_t  mem_address,
    output logic   branch_taken
);

    logic [15:0] imm;
    word_t       imm_sext;
    word_t       imm_zext;
    word_t       operand_b;
    logic        sign_taken;

    assign imm      = imm16(instr);
    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'h0000, imm};

    // logical immediates zero-extend, the rest sign-extend
    always_comb begin
        if (!ctrl.use_imm) begin
            operand_b = op_b;
        end else if (ctrl.imm_zero_ext) begin
            operand_b = imm_zext;
        end else begin
            operand_b = imm_sext;
        end
    end

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:  result = op_a + operand_b;
            ALU_SUB:  result = op_a - operand_b;
            ALU_AND:  result = op_a & operand_b;
            ALU_OR:   result = op_a | operand_b;
            ALU_XOR:  result = op_a ^ operand_b;
            ALU_SLT:  result = word_t'($signed(op_a) < $signed(operand_b));
            ALU_SLTU: result = word_t'(op_a < operand_b);
            // shifts act on rt by shamt
            ALU_SLL:  result = op_b << instr.shamt;
            ALU_SRL:  result = op_b >> instr.shamt;
            ALU_LUI:  result = {imm, 16'h0000};
            default:  result = '0;
        endcase
    end

    assign mem_address = op_a + imm_sext;

    // rt bit 0 set means bgezal, clear means bltzal
    assign sign_taken = instr.rt[0] ? !op_a[31] : op_a[31];

    assign branch_taken = (ctrl.branch_eq && op_a == op_b)
                       || (ctrl.branch_ne && op_a != op_b)
                       || (ctrl.branch_sign && sign_taken);

endmodule

//--- source/mips_multiplier.sv
module mips_multiplier
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
    input  word_t op_a,
    input  word_t op_b,
    input  logic  signed_mode,
    output hilo_t product
);

    logic signed [63:0] product_signed;
    logic        [63:0] product_unsigned;

    // operands widened to 64 bits before the multiply
    assign product_signed   = 64'($signed(op_a)) * 64'($signed(op_b));
    assign product_unsigned = {32'h0, op_a} * {32'h0, op_b};

    always_comb begin
        if (signed_mode) begin
            product = hilo_t'(product_signed);
        end else begin
            product = hilo_t'(product_unsigned);
        end
    end

endmodule

//--- source/mips_cpu_harvard.sv
`include "mips_config.svh"

module mips_cpu_harvard
    import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  clk_enable,
    output logic  active,
    output word_t register_v0,
    output word_t instr_address,
    input  word_t instr_readdata,
    output word_t data_address,
    output word_t data_writedata,
    output logic  data_read,
    output logic  data_write,
    input  word_t data_readdata
);

    instr_t instr;
    ctrl_t  ctrl;
    word_t  pc;
    word_t  pc_plus4;
    word_t  pc_next;
    word_t  rs_data;
    word_t  rt_data;
    word_t  alu_result;
    word_t  branch_offset;
    hilo_t  product;
    hilo_t  hilo;
    logic   branch_taken;
    logic   at_halt;
    logic   step;
    logic   [4:0] wb_index;
    word_t  wb_data;

    assign instr    = instr_t'(instr_readdata);
    assign pc_plus4 = pc + 32'd4;
    assign at_halt  = (pc == `MIPS_HALT_ADDR);

    // one instruction retires per enabled cycle, none at the halt address
    assign step = clk_enable && active && !at_halt;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b1;
        end else if (clk_enable && at_halt) begin
            active <= 1'b0;
        end
    end

    mips_decoder decoder_i (
        .instr (instr),
        .ctrl  (ctrl)
    );

    mips_regfile regfile_i (
        .clk          (clk),
        .reset        (reset),
        .write_en     (step && ctrl.reg_write),
        .read_a_index (instr.rs),
        .read_b_index (instr.rt),
        .write_index  (wb_index),
        .write_data   (wb_data),
        .read_a_data  (rs_data),
        .read_b_data  (rt_data),
        .register_v0  (register_v0)
    );

    mips_alu alu_i (
        .op_a         (rs_data),
        .op_b         (rt_data),
        .instr        (instr),
        .ctrl         (ctrl),
        .result       (alu_result),
        .mem_address  (data_address),
        .branch_taken (branch_taken)
    );

    mips_multiplier multiplier_i (
        .op_a        (rs_data),
        .op_b        (rt_data),
        .signed_mode (ctrl.mul_signed),
        .product     (product)
    );

    mips_state_reg #(
        .payload_t   (hilo_t),
        .RESET_VALUE ('0)
    ) hilo_reg (
        .clk    (clk),
        .reset  (reset),
        .enable (step && ctrl.mul_start),
        .d      (product),
        .q      (hilo)
    );

    // next pc, branch first then jumps
    assign branch_offset = {{14{instr_readdata[15]}}, instr_readdata[15:0], 2'b00};

    always_comb begin
        if (branch_taken) begin
            pc_next = pc_plus4 + branch_offset;
        end else if (ctrl.jump_imm) begin
            pc_next = {pc_plus4[31:28], instr_readdata[25:0], 2'b00};
        end else if (ctrl.jump_reg) begin
            pc_next = rs_data;
        end else begin
            pc_next = pc_plus4;
        end
    end

    mips_state_reg #(
        .payload_t   (word_t),
        .RESET_VALUE (word_t'(`MIPS_RESET_VECTOR))
    ) pc_reg (
        .clk    (clk),
        .reset  (reset),
        .enable (step),
        .d      (pc_next),
        .q      (pc)
    );

    // writeback destination and value
    always_comb begin
        case (ctrl.dst_sel)
            DST_RD:  wb_index = instr.rd;
            DST_RA:  wb_index = 5'd31;
            default: wb_index = instr.rt;
        endcase
    end

    always_comb begin
        case (ctrl.wb_sel)
            WB_MEM:  wb_data = data_readdata;
            WB_HI:   wb_data = hilo.hi;
            WB_LO:   wb_data = hilo.lo;
            // no delay slot, yet the return lands past pc+4
            WB_LINK: wb_data = pc + 32'd8;
            default: wb_data = alu_result;
        endcase
    end

    assign instr_address  = pc;
    assign data_writedata = rt_data;
    assign data_read      = ctrl.mem_read;

    // store strobe stays low while reset is held
    assign data_write = ctrl.mem_write && step && !reset;

endmodule

//--- tests/mips_cpu_assert.sv
module mips_cpu_assert
    import mips_isa_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  active,
    input logic  data_read,
    input logic  data_write,
    input word_t instr_address
);
    timeunit 1ns;
    timeprecision 100ps;

    // failed checks so far
    int unsigned fail_count = 0;

    // a memory access is a read or a write, never both
    read_write_exclusive: assert property (
        @(posedge clk) disable iff (reset) !(data_read && data_write)
    ) else begin
        fail_count = fail_count + 1;
        $error("data_read and data_write are high together");
    end

    no_store_when_halted: assert property (
        @(posedge clk) disable iff (reset) !active |-> !data_write
    ) else begin
        fail_count = fail_count + 1;
        $error("data_write is high while active is low");
    end

    // fetches are whole words
    fetch_word_aligned: assert property (
        @(posedge clk) disable iff (reset) instr_address[1:0] == 2'b00
    ) else begin
        fail_count = fail_count + 1;
        $error("instr_address is not word aligned");
    end

endmodule

bind mips_cpu_harvard mips_cpu_assert port_checks_i (
    .clk           (clk),
    .reset         (reset),
    .active        (active),
    .data_read     (data_read),
    .data_write    (data_write),
    .instr_address (instr_address)
);

//--- tests/mips_cpu_tb.sv
`include "mips_config.svh"

module mips_cpu_tb
    import mips_isa_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    localparam logic [4:0] r_zero = 5'd0;
    localparam logic [4:0] r_v0   = 5'd2;
    localparam logic [4:0] r_base = 5'd8;
    localparam logic [4:0] r_a    = 5'd9;
    localparam logic [4:0] r_b    = 5'd10;
    localparam logic [4:0] r_t    = 5'd11;
    localparam logic [4:0] r_sub  = 5'd12;
    localparam logic [4:0] r_ra   = 5'd31;
    localparam word_t ram_base    = 32'h0000_1000;
    // subroutine sits at rom word 60
    localparam word_t sub_addr    = `MIPS_RESET_VECTOR + 32'd240;

    logic       clk;
    logic       reset;
    logic       clk_enable;
    logic       active;
    word_t      register_v0;
    word_t      instr_address;
    word_t      instr_readdata;
    word_t      data_address;
    word_t      data_writedata;
    logic       data_read;
    logic       data_write;
    word_t      data_readdata;
    word_t      rom [64];
    word_t      ram [1024];
    logic       in_ram;
    logic [5:0] prog_len = '0;
    logic [7:0] slot = '0;
    logic       built = 1'b0;
    word_t      a;
    word_t      b;
    word_t      exp_v0;
    store_t     expected[$];
    store_t     exp_store;

    mips_cpu_harvard mips_cpu_harvard_i (
        .clk            (clk),
        .reset          (reset),
        .clk_enable     (clk_enable),
        .active         (active),
        .register_v0    (register_v0),
        .instr_address  (instr_address),
        .instr_readdata (instr_readdata),
        .data_address   (data_address),
        .data_writedata (data_writedata),
        .data_read      (data_read),
        .data_write     (data_write),
        .data_readdata  (data_readdata)
    );

    // both memories read combinationally, fetches outside the rom give a nop
    assign instr_readdata = ((instr_address & 32'hFFFF_FF00) == `MIPS_RESET_VECTOR)
                          ? rom[instr_address[7:2]] : '0;
    assign in_ram         = (data_address[31:12] == 20'h00001);
    assign data_readdata  = in_ram ? ram[data_address[11:2]] : '0;

    always @(posedge clk) begin
        if (data_write && in_ram) begin
            ram[data_address[11:2]] <= data_writedata;
        end
    end

    task automatic report_mismatch(input string name, input word_t got, input word_t want);
        $display("** Error %s: got 0x%08h, expected 0x%08h", name, got, want);
        $display("Done: errors found");
        $fatal(1, "%s mismatch", name);
    endtask

    task automatic abort_run(input string why);
        $display("Error: %s", why);
        $display("Done: errors found");
        $fatal(1, "%s", why);
    endtask

    function automatic word_t rtype_word(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                         logic [4:0] shamt, funct_e funct);
        return {OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic word_t itype_word(opcode_e op, logic [4:0] rs, logic [4:0] rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jump_word(opcode_e op, word_t target);
        return {op, target[27:2]};
    endfunction

    task automatic emit(input word_t w);
        rom[prog_len] = w;
        prog_len = prog_len + 6'd1;
    endtask

    // sw to the next free slot, queued with the value it must carry
    task automatic add_checked_store(input logic [4:0] rt, input word_t value);
        emit(itype_word(OP_SW, r_base, rt, {6'h00, slot, 2'b00}));
        expected.push_back('{addr: ram_base + {22'h0, slot, 2'b00}, data: value});
        slot = slot + 8'd1;
    endtask

    task automatic build_program();
        logic [63:0] prod_s;
        logic [63:0] prod_u;
        word_t       poison;
        word_t       jal_pc;
        prod_s = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        prod_u = {32'h0, a} * {32'h0, b};
        poison = itype_word(OP_SW, r_base, r_zero, 16'h03FC);
        rom = '{default: '0};
        emit(itype_word(OP_ADDIU, r_zero, r_base, ram_base[15:0]));
        emit(itype_word(OP_LUI, r_zero, r_a, a[31:16]));
        emit(itype_word(OP_ORI, r_a, r_a, a[15:0]));
        emit(itype_word(OP_LUI, r_zero, r_b, b[31:16]));
        emit(itype_word(OP_ORI, r_b, r_b, b[15:0]));
        // first three slots get reloaded for v0
        emit(rtype_word(r_a, r_b, r_t, 5'd0, F_ADDU));
        add_checked_store(r_t, a + b);
        emit(rtype_word(r_a, r_b, r_t, 5'd0, F_SUBU));
        add_checked_store(r_t, a - b);
        emit(rtype_word(r_a, r_b, r_t, 5'd0, F_AND));
        add_checked_store(r_t, a & b);
        emit(rtype_word(r_a, r_b, r_t, 5'd0, F_OR));
        add_checked_store(r_t, a | b);
        emit(rtype_word(r_a, r_b, r_t, 5'd0, F_XOR));
        add_checked_store(r_t, a ^ b);
        emit(rtype_word(r_a, r_b, r_t, 5'd0, F_SLT));
        add_checked_store(r_t, {31'b0, $signed(a) < $signed(b)});
        emit(rtype_word(r_a, r_b, r_t, 5'd0, F_SLTU));
        add_checked_store(r_t, {31'b0, a < b});
        emit(rtype_word(r_zero, r_a, r_t, 5'd5, F_SLL));
        add_checked_store(r_t, a << 5);
        emit(rtype_word(r_zero, r_b, r_t, 5'd7, F_SRL));
        add_checked_store(r_t, b >> 7);
        emit(itype_word(OP_ADDIU, r_a, r_t, 16'h8123));
        add_checked_store(r_t, a + 32'hFFFF_8123);
        emit(itype_word(OP_ANDI, r_a, r_t, 16'hF0F0));
        add_checked_store(r_t, a & 32'h0000_F0F0);
        emit(itype_word(OP_XORI, r_b, r_t, 16'h5A5A));
        add_checked_store(r_t, b ^ 32'h0000_5A5A);
        emit(itype_word(OP_SLTI, r_a, r_t, 16'hFFFD));
        add_checked_store(r_t, {31'b0, $signed(a) < -32'sd3});
        emit(rtype_word(r_a, r_b, r_zero, 5'd0, F_MULT));
        emit(rtype_word(r_zero, r_zero, r_t, 5'd0, F_MFHI));
        add_checked_store(r_t, prod_s[63:32]);
        emit(rtype_word(r_zero, r_zero, r_t, 5'd0, F_MFLO));
        add_checked_store(r_t, prod_s[31:0]);
        emit(rtype_word(r_a, r_b, r_zero, 5'd0, F_MULTU));
        emit(rtype_word(r_zero, r_zero, r_t, 5'd0, F_MFHI));
        add_checked_store(r_t, prod_u[63:32]);
        emit(rtype_word(r_zero, r_zero, r_t, 5'd0, F_MFLO));
        add_checked_store(r_t, prod_u[31:0]);
        // taken beq and bne each hop over a poison store
        emit(itype_word(OP_BEQ, r_a, r_a, 16'h0001));
        emit(poison);
        emit(itype_word(OP_BNE, r_a, r_b, 16'h0001));
        emit(poison);
        emit(itype_word(OP_BEQ, r_a, r_b, 16'h0001));
        add_checked_store(r_a, a);
        // call returns to pc+8, so the word after jal never runs
        jal_pc = `MIPS_RESET_VECTOR + {24'h0, prog_len, 2'b00};
        emit(jump_word(OP_JAL, sub_addr));
        emit(poison);
        add_checked_store(r_sub, a + 32'h0000_0011);
        add_checked_store(r_ra, jal_pc + 32'd8);
        emit(itype_word(OP_LW, r_base, r_t, 16'h0000));
        emit(itype_word(OP_LW, r_base, r_sub, 16'h0004));
        emit(itype_word(OP_LW, r_base, r_ra, 16'h0008));
        emit(rtype_word(r_t, r_sub, r_v0, 5'd0, F_ADDU));
        emit(rtype_word(r_v0, r_ra, r_v0, 5'd0, F_ADDU));
        exp_v0 = (a + b) + (a - b) + (a & b);
        // jr r0 heads for the halt address
        emit(rtype_word(r_zero, r_zero, r_zero, 5'd0, F_JR));
        rom[6'd60] = itype_word(OP_ADDIU, r_a, r_sub, 16'h0011);
        rom[6'd61] = rtype_word(r_ra, r_zero, r_zero, 5'd0, F_JR);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!reset) begin
            clk_enable <= ($urandom() % 5) != 0;
        end
    end

    always @(posedge clk) begin
        if (mips_cpu_harvard_i.port_checks_i.fail_count != 0) begin
            abort_run("a port assertion in mips_cpu_assert failed");
        end
    end

    // stores must appear in program order
    always @(posedge clk) begin
        if (data_write) begin
            if (expected.size() == 0) begin
                abort_run("store seen after the last expected store");
            end else begin
                exp_store = expected.pop_front();
                assert (data_address == exp_store.addr)
                    else report_mismatch("data_address", data_address, exp_store.addr);
                assert (data_writedata == exp_store.data)
                    else report_mismatch("data_writedata", data_writedata, exp_store.data);
            end
        end
    end

    pc_frozen_when_disabled: assert property (
        @(posedge clk) disable iff (reset) !clk_enable |=> $stable(instr_address)
    ) else abort_run("instr_address moved in a cycle with clk_enable low");

    pc_parked_after_halt: assert property (
        @(posedge clk) disable iff (reset) !active |-> instr_address == `MIPS_HALT_ADDR
    ) else report_mismatch("instr_address", instr_address, `MIPS_HALT_ADDR);

    // only an lw fetch reads data memory
    read_strobe_on_lw: assert property (
        @(posedge clk) disable iff (reset) data_read == (instr_readdata[31:26] == OP_LW)
    ) else report_mismatch("data_read", {31'b0, $sampled(data_read)},
                           {31'b0, $sampled(instr_readdata[31:26] == OP_LW)});

    initial begin
        wait (built);
        #(4 * (2 * int'(prog_len) + 4));
        abort_run("watchdog expired before the cpu halted");
    end

    initial begin
        reset = 1'b1;
        clk_enable = 1'b1;
        void'($urandom(82));
        a = $urandom();
        b = $urandom();
        if (b == a) begin
            b = ~a;
        end
        build_program();
        built = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        assert (active == 1'b1)
            else abort_run("active is low while reset is held");
        assert (data_write == 1'b0)
            else report_mismatch("data_write", {31'b0, data_write}, 32'h0);
        assert (instr_address == `MIPS_RESET_VECTOR)
            else report_mismatch("instr_address", instr_address, `MIPS_RESET_VECTOR);
        @(posedge clk);
        reset <= 1'b0;
        wait (active == 1'b0);
        // a few more edges to catch stray stores or pc movement
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (register_v0 !== exp_v0) begin
            report_mismatch("register_v0", register_v0, exp_v0);
        end else if (expected.size() != 0) begin
            abort_run("cpu halted before all expected stores happened");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- all.f
+incdir+include
source/mips_isa_pkg.sv
source/mips_ctrl_pkg.sv
source/mips_state_reg.sv
source/mips_decoder.sv
source/mips_regfile.sv
source/mips_alu.sv
source/mips_multiplier.sv
source/mips_cpu_harvard.sv
tests/mips_cpu_assert.sv
tests/mips_cpu_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module mips_cpu_tb -f all.f -o mips_cpu_sim
# a failed port assertion must not stop the run before the testbench reports it
./obj_dir/mips_cpu_sim +verilator+error+limit+10
